// ==== Makefile ====
# Verilator build and run of the serial port engine testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP       := tb_jsp_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+.
jsp_pkg.sv
jsp_fifo.sv
jsp_in_ctrl.sv
jsp_out_ctrl.sv
jsp_top.sv
tb_jsp_top.sv

// ==== jsp_fifo.sv ====
// Synchronous byte FIFO with fill level
// Circular buffer, read and write pointers, fill counter
// Valid/ready on both sides, push ignored when full, pop ignored when empty

`timescale 1ns/1ps
`default_nettype none

`include "jsp_settings.svh"

module jsp_fifo (
  input  logic                    tck_i,
  input  logic                    rst_i,
  input  logic [`JSP_BYTE_W-1:0]  in_data_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output logic [`JSP_BYTE_W-1:0]  out_data_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic [`JSP_COUNT_W-1:0] level_o
);

  localparam int depth_lp   = `JSP_FIFO_DEPTH;
  localparam int ptr_w_lp   = $clog2(depth_lp);
  localparam int count_w_lp = `JSP_COUNT_W;
  localparam logic [ptr_w_lp-1:0]     ptr_last_lp = ptr_w_lp'(depth_lp - 1);
  localparam logic [`JSP_COUNT_W-1:0] full_lvl_lp = count_w_lp'(depth_lp);

  logic [`JSP_BYTE_W-1:0]  mem_q [depth_lp];  // Storage, no reset
  logic [ptr_w_lp-1:0]     wr_ptr_q;
  logic [ptr_w_lp-1:0]     rd_ptr_q;
  logic [`JSP_COUNT_W-1:0] level_q;           // Entries held
  logic                    do_push;
  logic                    do_pop;

  assign in_ready_o  = (level_q != full_lvl_lp);
  assign out_valid_o = (level_q != '0);
  assign do_push     = in_valid_i && in_ready_o;   // Transfer on valid and ready
  assign do_pop      = out_ready_i && out_valid_o;
  assign out_data_o  = mem_q[rd_ptr_q];           // Head is always visible
  assign level_o     = level_q;

  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  // Pointers wrap at the last entry so any depth works
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_last_lp) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_last_lp) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== jsp_in_ctrl.sv ====
// Input control for the serial port engine
// FSM for start bit, count byte and data bytes from TDI
// Write bit counter, user and space byte counters, TDI history
// Drives the push strobe and push data of the receive FIFO

`timescale 1ns/1ps
`default_nettype none

`include "jsp_settings.svh"

module jsp_in_ctrl #(
  parameter bit multi_chain_p = 1'b1  // Wait for a start bit before the count byte
) (
  input  logic                    tck_i,
  input  logic                    rst_i,
  input  jsp_pkg::tap_ctrl_t      tap_i,
  input  logic                    tdi_i,
  input  logic [`JSP_COUNT_W-1:0] rx_level_i,
  output logic                    push_o,
  output logic [`JSP_BYTE_W-1:0]  push_data_o
);

  import jsp_pkg::*;

  localparam int bit_w_lp   = $clog2(`JSP_BYTE_W);
  localparam int count_w_lp = `JSP_COUNT_W;
  localparam logic [bit_w_lp-1:0] bit_max_lp = bit_w_lp'(`JSP_BYTE_W - 1);

  wr_state_e               state_q;
  wr_state_e               state_d;
  logic [bit_w_lp-1:0]     bit_cnt_q;    // Bits shifted in of the current byte
  logic [`JSP_COUNT_W-1:0] space_q;      // Receive space left, taken at capture
  logic [`JSP_COUNT_W-1:0] user_q;       // Bytes the host still announces
  logic [`JSP_BYTE_W-2:0]  hist_q;       // Last 7 TDI bits, newest at the top
  logic [`JSP_COUNT_W-1:0] free_space;
  logic [`JSP_COUNT_W-1:0] user_count;
  logic                    start;
  logic                    bit_max;
  logic                    byte_done;
  logic                    counts_ok;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  assign free_space  = count_w_lp'(`JSP_FIFO_DEPTH) - rx_level_i;
  assign start       = tap_i.capture && tap_i.select;
  assign bit_max     = (bit_cnt_q == bit_max_lp);
  assign byte_done   = tap_i.shift && bit_max;    // Eighth bit on TDI now
  assign push_data_o = {tdi_i, hist_q};           // LSB arrived first
  assign user_count  = push_data_o[`JSP_BYTE_W-1 -: `JSP_COUNT_W];
  assign counts_ok   = (space_q != '0) && (user_q != '0);

  // Push on the edge that samples the last data bit
  assign push_o = (state_q == WR_XFER) && byte_done && counts_ok;

  // Shift history, payload only
  always_ff @(posedge tck_i) begin
    if (tap_i.shift) begin
      hist_q <= {tdi_i, hist_q[`JSP_BYTE_W-2:1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Input FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WR_IDLE: begin
        if (start) begin
          if (multi_chain_p) begin
            state_d = WR_WAIT;
          end else begin
            state_d = WR_COUNTS;
          end
        end
      end
      WR_WAIT: begin
        if (tap_i.shift && tdi_i) state_d = WR_COUNTS;  // Start bit, not counted
      end
      WR_COUNTS: begin
        if (byte_done) state_d = WR_XFER;
      end
      WR_XFER: begin
        state_d = WR_XFER;  // Stay until update
      end
      default: state_d = WR_IDLE;
    endcase
    // Update ends the scan, partial byte is dropped
    if (tap_i.update) state_d = WR_IDLE;
  end

  // State and counters, nothing moves outside Shift-DR
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= WR_IDLE;
      bit_cnt_q <= '0;
      space_q   <= '0;
      user_q    <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        WR_IDLE: begin
          if (start) begin
            bit_cnt_q <= '0;
            space_q   <= free_space;  // Space only grows from here on
          end
        end
        WR_COUNTS: begin
          if (tap_i.shift) begin
            bit_cnt_q <= bit_max ? '0 : bit_cnt_q + 1'b1;
            if (bit_max) user_q <= user_count;  // Upper nibble of count byte
          end
        end
        WR_XFER: begin
          if (tap_i.shift) begin
            bit_cnt_q <= bit_max ? '0 : bit_cnt_q + 1'b1;
            if (push_o) begin
              space_q <= space_q - 1'b1;
              user_q  <= user_q - 1'b1;
            end
          end
        end
        default: ;  // WR_WAIT holds the counters
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== jsp_out_ctrl.sv ====
// Output control for the serial port engine
// FSM for the status byte and the data bytes to TDO
// Read bit counter, output byte counter, output shift register
// Drives the pop strobe of the transmit FIFO

`timescale 1ns/1ps
`default_nettype none

`include "jsp_settings.svh"

module jsp_out_ctrl (
  input  logic                    tck_i,
  input  logic                    rst_i,
  input  jsp_pkg::tap_ctrl_t      tap_i,
  input  logic [`JSP_BYTE_W-1:0]  tx_data_i,
  input  logic [`JSP_COUNT_W-1:0] tx_level_i,
  input  logic [`JSP_COUNT_W-1:0] rx_level_i,
  output logic                    pop_o,
  output logic                    module_tdo_o
);

  import jsp_pkg::*;

  localparam int bit_w_lp   = $clog2(`JSP_BYTE_W);
  localparam int count_w_lp = `JSP_COUNT_W;
  localparam logic [bit_w_lp-1:0] bit_max_lp = bit_w_lp'(`JSP_BYTE_W - 1);

  rd_state_e               state_q;
  rd_state_e               state_d;
  logic [bit_w_lp-1:0]     bit_cnt_q;    // Bits shifted out of the current byte
  logic [`JSP_COUNT_W-1:0] out_cnt_q;    // Transmit bytes still to send
  logic [`JSP_BYTE_W-1:0]  shift_q;      // Parallel load, shifts toward bit 0
  logic [`JSP_COUNT_W-1:0] free_space;
  logic [`JSP_BYTE_W-1:0]  status_byte;
  logic                    start;
  logic                    bit_max;
  logic                    byte_end;
  logic                    out_cnt_zero;
  logic                    load_head;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  assign free_space   = count_w_lp'(`JSP_FIFO_DEPTH) - rx_level_i;
  assign status_byte  = {tx_level_i, free_space};  // Fill high, space low
  assign start        = tap_i.capture && tap_i.select && (state_q == RD_IDLE);
  assign bit_max      = (bit_cnt_q == bit_max_lp);
  assign byte_end     = tap_i.shift && bit_max;
  assign out_cnt_zero = (out_cnt_q == '0);

  // Next byte replaces the shift at the end of each group of 8 bits
  assign load_head = byte_end && !out_cnt_zero &&
                     ((state_q == RD_COUNTS) || (state_q == RD_XFER));

  // Ack of the loaded head during its first bit
  assign pop_o = (state_q == RD_RDACK) && tap_i.shift && !out_cnt_zero;

  assign module_tdo_o = shift_q[0];

  //////////////////////////////////////////////////////////////////////
  // Output FSM
  //////////////////////////////////////////////////////////////////////

  // No start bit on this side
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RD_IDLE: begin
        if (start) state_d = RD_COUNTS;
      end
      RD_COUNTS: begin
        if (byte_end) state_d = RD_RDACK;
      end
      RD_RDACK: begin
        if (tap_i.shift) state_d = RD_XFER;  // Single bit in this state
      end
      RD_XFER: begin
        if (byte_end) state_d = RD_RDACK;
      end
      default: state_d = RD_IDLE;
    endcase
    if (tap_i.update) state_d = RD_IDLE;     // Back to idle on update
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= RD_IDLE;
      bit_cnt_q <= '0;
      out_cnt_q <= '0;
      shift_q   <= '0;  // Keeps TDO low out of reset
    end else begin
      state_q <= state_d;
      if (start) begin
        shift_q   <= status_byte;
        out_cnt_q <= tx_level_i;   // Fill only grows during the scan
        bit_cnt_q <= '0;
      end else if ((state_q != RD_IDLE) && tap_i.shift) begin
        bit_cnt_q <= bit_max ? '0 : bit_cnt_q + 1'b1;
        if (load_head) begin
          shift_q <= tx_data_i;
        end else begin
          shift_q <= {1'b0, shift_q[`JSP_BYTE_W-1:1]};  // LSB first, zero fill
        end
        // Status byte end loads without counting
        if (load_head && (state_q == RD_XFER)) begin
          out_cnt_q <= out_cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== jsp_pkg.sv ====
// Types shared by the serial port engine
// Input and output FSM state encodings
// TAP state decode bundle fed to both controllers

`default_nettype none

package jsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  // Input side, host to receive FIFO
  typedef enum logic [1:0] {
    WR_IDLE   = 2'h0,  // Waiting for capture with select
    WR_WAIT   = 2'h1,  // Waiting for the start bit (multi-device chain)
    WR_COUNTS = 2'h2,  // Shifting in the count byte
    WR_XFER   = 2'h3   // Shifting in data bytes
  } wr_state_e;

  // Output side, transmit FIFO to host
  typedef enum logic [1:0] {
    RD_IDLE   = 2'h0,  // Waiting for capture with select
    RD_COUNTS = 2'h1,  // Shifting out the status byte
    RD_RDACK  = 2'h2,  // First bit of a data byte, head gets popped
    RD_XFER   = 2'h3   // Remaining bits of a data byte
  } rd_state_e;

  //////////////////////////////////////////////////////////////////////
  // TAP control
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic capture;  // Capture-DR
    logic shift;    // Shift-DR
    logic update;   // Update-DR
    logic select;   // This module is selected in the chain
  } tap_ctrl_t;

endpackage

`default_nettype wire

// ==== jsp_settings.svh ====
// Shared widths and depth of the JTAG serial port engine
// Byte width, counter and level width, FIFO depth

`ifndef JSP_SETTINGS_SVH
`define JSP_SETTINGS_SVH

// Width of one byte moved over the scan chain
`define JSP_BYTE_W 8

// Byte counters and FIFO levels, one nibble of the status byte
`define JSP_COUNT_W 4

// Entries per FIFO
// Must stay at or below the largest count value (15)
`define JSP_FIFO_DEPTH 8

`endif

// ==== jsp_top.sv ====
// Top level of the JTAG serial port engine
// Input and output controllers
// Receive and transmit byte FIFOs with valid/ready streams

`timescale 1ns/1ps
`default_nettype none

`include "jsp_settings.svh"

module jsp_top #(
  parameter bit multi_chain_p = 1'b1
) (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  jsp_pkg::tap_ctrl_t     tap_i,
  input  logic                   tdi_i,
  output logic                   module_tdo_o,
  // Receive stream, host to system
  output logic [`JSP_BYTE_W-1:0] rx_data_o,
  output logic                   rx_valid_o,
  input  logic                   rx_ready_i,
  // Transmit stream, system to host
  input  logic [`JSP_BYTE_W-1:0] tx_data_i,
  input  logic                   tx_valid_i,
  output logic                   tx_ready_o
);

  logic                    push;
  logic [`JSP_BYTE_W-1:0]  push_data;
  logic                    pop;
  logic [`JSP_BYTE_W-1:0]  tx_head;    // Head of the transmit FIFO
  logic [`JSP_COUNT_W-1:0] rx_level;
  logic [`JSP_COUNT_W-1:0] tx_level;

  jsp_in_ctrl #(
    .multi_chain_p (multi_chain_p)
  ) u_in_ctrl (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .tap_i       (tap_i),
    .tdi_i       (tdi_i),
    .rx_level_i  (rx_level),
    .push_o      (push),
    .push_data_o (push_data)
  );

  jsp_out_ctrl u_out_ctrl (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .tap_i        (tap_i),
    .tx_data_i    (tx_head),
    .tx_level_i   (tx_level),
    .rx_level_i   (rx_level),
    .pop_o        (pop),
    .module_tdo_o (module_tdo_o)
  );

  // Space is tracked by the input byte counter, ready unused
  jsp_fifo u_rx_fifo (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .in_data_i   (push_data),
    .in_valid_i  (push),
    .in_ready_o  (),
    .out_data_o  (rx_data_o),
    .out_valid_o (rx_valid_o),
    .out_ready_i (rx_ready_i),
    .level_o     (rx_level)
  );

  // Pops are bounded by the output byte count
  jsp_fifo u_tx_fifo (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .in_data_i   (tx_data_i),
    .in_valid_i  (tx_valid_i),
    .in_ready_o  (tx_ready_o),
    .out_data_o  (tx_head),
    .out_valid_o (),
    .out_ready_i (pop),
    .level_o     (tx_level)
  );

endmodule

`default_nettype wire

// ==== tb_jsp_top.sv ====
// Self-checking testbench for the JTAG serial port engine
// TAP driver tasks for capture, shift and update
// Galois LFSR stimulus, stream drivers, immediate assertion checks

`timescale 1ns/1ps
`default_nettype none

`include "jsp_settings.svh"

module tb_jsp_top;

  import jsp_pkg::*;

  localparam int wait_limit_lp = 200;  // Cycles allowed for any handshake

  logic                   tck_i;
  logic                   rst_i;
  tap_ctrl_t              tap_i;
  logic                   tdi_i;
  logic                   module_tdo_o;
  logic [`JSP_BYTE_W-1:0] rx_data_o;
  logic                   rx_valid_o;
  logic                   rx_ready_i;
  logic [`JSP_BYTE_W-1:0] tx_data_i;
  logic                   tx_valid_i;
  logic                   tx_ready_o;

  logic [15:0]            lfsr_q;     // Stimulus LFSR state
  logic [`JSP_BYTE_W-1:0] scan_q[$];  // Data bytes of the next host write
  logic [`JSP_BYTE_W-1:0] rx_exp[$];  // Bytes expected on the receive stream
  int                     err_count;
  int                     check_count;
  int                     test_count;
  int                     test_err_base;

  jsp_top #(
    .multi_chain_p (1'b1)
  ) u_jsp_top (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .tap_i        (tap_i),
    .tdi_i        (tdi_i),
    .module_tdo_o (module_tdo_o),
    .rx_data_o    (rx_data_o),
    .rx_valid_o   (rx_valid_o),
    .rx_ready_i   (rx_ready_i),
    .tx_data_i    (tx_data_i),
    .tx_valid_i   (tx_valid_i),
    .tx_ready_o   (tx_ready_o)
  );

  always #20 tck_i = ~tck_i;  // 40 ns TCK

  ////////////////////////////////////////////////////////////////////
  // Stimulus and checking helpers
  ////////////////////////////////////////////////////////////////////

  // Galois form with taps at 16, 14, 13 and 11
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < n; i++) val[i] = lfsr_bit();  // One step per bit
    return val;
  endfunction

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
    check_count++;
    assert (got === exp) else begin
      $display("Fail at time %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, got);
      err_count++;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (err_count == test_err_base) begin
      $display("Test %0d (%s): ok", test_count, name);
    end else begin
      $display("Test %0d (%s): %0d errors", test_count, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  // Capture-DR with this module selected
  task automatic start_scan();
    @(negedge tck_i);
    tap_i.capture = 1'b1;
    tap_i.shift   = 1'b0;
    tap_i.update  = 1'b0;
    tap_i.select  = 1'b1;
  endtask

  // TDO is sampled before the rising edge that advances it
  task automatic shift_bit(input logic b, output logic tdo);
    @(negedge tck_i);
    tdo           = module_tdo_o;
    tap_i.capture = 1'b0;
    tap_i.shift   = 1'b1;
    tdi_i         = b;
  endtask

  task automatic shift_byte(input logic [7:0] b, output logic [7:0] tdo_byte);
    logic t;
    for (int i = 0; i < 8; i++) begin  // LSB first
      shift_bit(b[i], t);
      tdo_byte[i] = t;
    end
  endtask

  task automatic end_scan();
    @(negedge tck_i);
    tap_i.shift  = 1'b0;
    tap_i.update = 1'b1;
    tdi_i        = 1'b0;
    @(negedge tck_i);
    tap_i.update = 1'b0;
    tap_i.select = 1'b0;
  endtask

  // Zeros, start bit, count byte, bytes of scan_q, then a partial byte
  task automatic host_write(input int zeros, input logic [3:0] count, input int partial_bits);
    logic       t;
    logic [7:0] tdo_byte;
    logic [7:0] part;
    part = random_bits(partial_bits);
    start_scan();
    repeat (zeros) shift_bit(1'b0, t);
    shift_bit(1'b1, t);
    shift_byte({count, 4'h0}, tdo_byte);
    foreach (scan_q[i]) shift_byte(scan_q[i], tdo_byte);
    for (int i = 0; i < partial_bits; i++) shift_bit(part[i], t);
    end_scan();
  endtask

  // Status byte of a scan with nothing on TDI
  task automatic read_status(output logic [7:0] status);
    start_scan();
    shift_byte(8'h00, status);
    end_scan();
  endtask

  task automatic send_tx(input logic [7:0] b);
    int waited;
    waited = 0;
    @(negedge tck_i);
    tx_data_i  = b;
    tx_valid_i = 1'b1;
    while (!tx_ready_o) begin
      if (waited == wait_limit_lp) timeout_fail("transmit stream ready");
      waited++;
      @(negedge tck_i);
    end
    @(negedge tck_i);  // Transfer on the edge in between
    tx_valid_i = 1'b0;
  endtask

  task automatic drain_rx(input int n);
    int         waited;
    logic [7:0] exp;
    for (int k = 0; k < n; k++) begin
      waited = 0;
      @(negedge tck_i);
      while (!rx_valid_o) begin
        if (waited == wait_limit_lp) timeout_fail("receive stream valid");
        waited++;
        @(negedge tck_i);
      end
      exp = rx_exp.pop_front();
      check_value("rx_data_o", exp, rx_data_o);
      rx_ready_i = 1'b1;
      @(negedge tck_i);
      rx_ready_i = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int               k;
    int               m;
    logic [7:0]       status;
    logic [7:0]       got;
    logic [7:0]       b;
    logic [7:0]       head;
    logic [7:0]       tx_exp[$];
    tck_i         = 1'b0;
    rst_i         = 1'b1;
    tap_i         = '0;
    tdi_i         = 1'b0;
    rx_ready_i    = 1'b0;
    tx_data_i     = '0;
    tx_valid_i    = 1'b0;
    lfsr_q        = 16'd7;  // Seed
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    test_err_base = 0;

    repeat (8) @(negedge tck_i);
    rst_i = 1'b0;
    @(negedge tck_i);
    check_value("module_tdo_o", 8'h00, 8'(module_tdo_o));
    check_value("rx_valid_o", 8'h00, 8'(rx_valid_o));
    check_value("tx_ready_o", 8'h01, 8'(tx_ready_o));
    finish_test("reset");

    // K bytes into the transmit FIFO while the receive side is empty
    k = random_bits(3) + 1;
    for (int i = 0; i < k; i++) begin
      b = random_bits(8);
      tx_exp.push_back(b);
      send_tx(b);
    end
    start_scan();
    shift_byte(8'h00, status);
    check_value("module_tdo_o status", {k[3:0], 4'd8}, status);
    finish_test("status byte");
    for (int i = 0; i < k; i++) begin
      shift_byte(8'h00, got);
      check_value("module_tdo_o byte", tx_exp[i], got);
    end
    end_scan();
    read_status(status);
    check_value("module_tdo_o fill nibble", 8'h00, {4'h0, status[7:4]});
    finish_test("transmit data");

    // Host write with the receive stream stalled
    m = random_bits(2) + 3;
    scan_q.delete();
    for (int i = 0; i < m; i++) begin
      b = random_bits(8);
      scan_q.push_back(b);
      rx_exp.push_back(b);
    end
    host_write(3, m[3:0], 0);
    head = rx_exp[0];
    repeat (4) begin
      @(negedge tck_i);
      check_value("rx_valid_o", 8'h01, 8'(rx_valid_o));
      check_value("rx_data_o held", head, rx_data_o);
    end
    drain_rx(m);
    check_value("rx_valid_o", 8'h00, 8'(rx_valid_o));
    finish_test("receive data");

    // Six bytes stay in the FIFO before four are announced with room for two
    scan_q.delete();
    for (int i = 0; i < 6; i++) begin
      b = random_bits(8);
      scan_q.push_back(b);
      rx_exp.push_back(b);
    end
    host_write(2, 4'd6, 0);
    scan_q.delete();
    for (int i = 0; i < 4; i++) begin
      b = random_bits(8);
      scan_q.push_back(b);
      if (i < 2) rx_exp.push_back(b);  // Excess gets refused
    end
    host_write(2, 4'd4, 0);
    read_status(status);
    check_value("module_tdo_o space nibble", 8'h00, {4'h0, status[3:0]});
    drain_rx(8);
    check_value("rx_valid_o", 8'h00, 8'(rx_valid_o));
    finish_test("space limit");

    // Update in the middle of a data byte
    scan_q.delete();
    host_write(1, 4'd1, 5);
    repeat (3) begin
      @(negedge tck_i);
      check_value("rx_valid_o", 8'h00, 8'(rx_valid_o));
    end
    b = random_bits(8);
    scan_q.push_back(b);
    rx_exp.push_back(b);
    host_write(0, 4'd1, 0);  // Next scan starts clean
    drain_rx(1);
    check_value("rx_valid_o", 8'h00, 8'(rx_valid_o));
    finish_test("abort");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
